// File: hw/mempool.sv
// Cluster top, cores are external and drive the plain request ports
// Request fields must stay stable while valid is high and ready is low
// Responses follow acceptance by exactly two cycles, no response ready

`timescale 1ns/10ps
`include "mempool_macros.svh"

module mempool (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic [`NUM_CORES-1:0] core_req_valid_i,
  input  mempool_pkg::addr_t    core_req_addr_i  [`NUM_CORES],
  input  tcdm_pkg::tcdm_op_e    core_req_op_i    [`NUM_CORES],
  input  tcdm_pkg::data_t       core_req_wdata_i [`NUM_CORES],
  input  tcdm_pkg::strb_t       core_req_be_i    [`NUM_CORES],
  output logic [`NUM_CORES-1:0] core_req_ready_o,
  output logic [`NUM_CORES-1:0] core_resp_valid_o,
  output tcdm_pkg::data_t       core_resp_rdata_o [`NUM_CORES]
);

  // One bank link per tile
  tcdm_if tile_bus [`NUM_TILES] ();

  variable_latency_interconnect i_interco (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .core_req_valid_i  (core_req_valid_i),
    .core_req_addr_i   (core_req_addr_i),
    .core_req_op_i     (core_req_op_i),
    .core_req_wdata_i  (core_req_wdata_i),
    .core_req_be_i     (core_req_be_i),
    .core_req_ready_o  (core_req_ready_o),
    .core_resp_valid_o (core_resp_valid_o),
    .core_resp_rdata_o (core_resp_rdata_o),
    .tile_o            (tile_bus)
  );

  for (genvar t = 0; t < `NUM_TILES; t++) begin : gen_tiles
    mempool_tile i_tile (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .bank_i  (tile_bus[t])
    );
  end

  // Elaboration checks
  if (`NUM_CORES % `CORES_PER_TILE != 0) begin : gen_bad_tiling
    $fatal(1, "[mempool] Core count is not divisible by cores per tile");
  end

  if ((`BANKING_FACTOR & (`BANKING_FACTOR - 1)) != 0) begin : gen_bad_banking
    $fatal(1, "[mempool] Banking factor must be a power of two");
  end

endmodule : mempool

// File: hw/mempool_macros.svh
// Cluster size settings shared by all design files
// NUM_CORES must be divisible by CORES_PER_TILE
// BANKING_FACTOR and WORDS_PER_BANK must be powers of two
// Derived values are not meant to be edited
`ifndef MEMPOOL_MACROS_SVH
`define MEMPOOL_MACROS_SVH

// Core and tile counts
`define NUM_CORES      4
`define CORES_PER_TILE 2
`define NUM_TILES      (`NUM_CORES / `CORES_PER_TILE)

// Banking
`define BANKING_FACTOR 2
`define NUM_BANKS      (`NUM_CORES * `BANKING_FACTOR)
`define BANKS_PER_TILE (`NUM_BANKS / `NUM_TILES)

// Rows per bank
`define WORDS_PER_BANK 64

// Word width in bits, a multiple of 8
`define DATA_WIDTH     32

`endif

// File: hw/mempool_pkg.sv
// Address map types of the cluster
// Byte addresses are word aligned by the interconnect, bits [1:0] are dropped
// Address bits above bank and row select are ignored, so the TCDM aliases

`include "mempool_macros.svh"

package mempool_pkg;

  // Byte address as issued by a core
  typedef logic [31:0] addr_t;

  // Index of the initiating core
  typedef logic [$clog2(`NUM_CORES)-1:0] core_id_t;

  // Row inside one bank
  typedef logic [$clog2(`WORDS_PER_BANK)-1:0] bank_row_t;

endpackage : mempool_pkg

// File: hw/mempool_tile.sv
// One tile of TCDM banks with a registered response stage
// Each bank serves at most one request per cycle
// Memory contents are undefined after reset

`timescale 1ns/10ps
`include "mempool_macros.svh"

module mempool_tile (
  input  logic  clk_i,
  input  logic  rst_n_i,
  tcdm_if.slave bank_i
);
  import mempool_pkg::*;
  import tcdm_pkg::*;

  logic [`BANKS_PER_TILE-1:0] resp_valid_q;
  core_id_t                   resp_ini_q   [`BANKS_PER_TILE];
  data_t                      resp_rdata_q [`BANKS_PER_TILE];

  for (genvar l = 0; l < `BANKS_PER_TILE; l++) begin : gen_bank
    data_t mem_q [`WORDS_PER_BANK];

    // Byte merge on write
    always_ff @(posedge clk_i) begin
      if (bank_i.req_valid[l] && bank_i.req_op[l] == TCDM_WRITE) begin
        for (int b = 0; b < `DATA_WIDTH/8; b++) begin
          if (bank_i.req_be[l][b]) begin
            mem_q[bank_i.req_row[l]][8*b +: 8] <= bank_i.req_wdata[l][8*b +: 8];
          end
        end
      end
    end

    // Old row content, also on writes
    always_ff @(posedge clk_i) begin
      if (bank_i.req_valid[l]) begin
        resp_rdata_q[l] <= mem_q[bank_i.req_row[l]];
        resp_ini_q[l]   <= bank_i.req_ini[l];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      resp_valid_q <= '0;
    end else begin
      resp_valid_q <= bank_i.req_valid;
    end
  end

  assign bank_i.resp_valid = resp_valid_q;
  assign bank_i.resp_ini   = resp_ini_q;
  assign bank_i.resp_rdata = resp_rdata_q;

endmodule : mempool_tile

// File: hw/rr_arbiter.sv
// Round-robin arbiter over all cores for one bank
// Grant is combinational, pointer only moves when adv_i is high
// Starvation bound is NUM_CORES cycles

`timescale 1ns/10ps
`include "mempool_macros.svh"

module rr_arbiter (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic [`NUM_CORES-1:0] req_i,
  input  logic                  adv_i,
  output logic [`NUM_CORES-1:0] gnt_o
);
  import mempool_pkg::*;

  core_id_t ptr_q;
  core_id_t win_idx;
  logic     found;

  // First requester at or after the pointer
  always_comb begin
    int idx;
    gnt_o   = '0;
    win_idx = ptr_q;
    found   = 1'b0;
    for (int i = 0; i < `NUM_CORES; i++) begin
      idx = (int'(ptr_q) + i) % `NUM_CORES;
      if (!found && req_i[idx]) begin
        found   = 1'b1;
        win_idx = core_id_t'(idx);
      end
    end
    if (found) begin
      gnt_o[win_idx] = 1'b1;
    end
  end

  // Winner drops to lowest priority
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ptr_q <= '0;
    end else if (adv_i && found) begin
      ptr_q <= (win_idx == core_id_t'(`NUM_CORES - 1)) ? '0 : win_idx + 1'b1;
    end
  end

endmodule : rr_arbiter

// File: hw/tcdm_if.sv
// Bank side link between the interconnect and one tile
// One entry per local bank, no ready in either direction
// Every valid must be consumed in the cycle it is seen

`timescale 1ns/10ps
`include "mempool_macros.svh"

interface tcdm_if;
  import mempool_pkg::*;
  import tcdm_pkg::*;

  // Requests towards the banks
  logic [`BANKS_PER_TILE-1:0] req_valid;
  bank_row_t                  req_row   [`BANKS_PER_TILE];
  tcdm_op_e                   req_op    [`BANKS_PER_TILE];
  data_t                      req_wdata [`BANKS_PER_TILE];
  strb_t                      req_be    [`BANKS_PER_TILE];
  core_id_t                   req_ini   [`BANKS_PER_TILE];

  // Responses, tagged with the initiator
  logic [`BANKS_PER_TILE-1:0] resp_valid;
  core_id_t                   resp_ini   [`BANKS_PER_TILE];
  data_t                      resp_rdata [`BANKS_PER_TILE];

  modport master (
    output req_valid, req_row, req_op, req_wdata, req_be, req_ini,
    input  resp_valid, resp_ini, resp_rdata
  );

  modport slave (
    input  req_valid, req_row, req_op, req_wdata, req_be, req_ini,
    output resp_valid, resp_ini, resp_rdata
  );

endinterface : tcdm_if

// File: hw/tcdm_pkg.sv
// TCDM transaction types
// Strobes hold one enable per data byte
// A write response carries no meaningful data

`include "mempool_macros.svh"

package tcdm_pkg;

  typedef logic [`DATA_WIDTH-1:0]   data_t;
  typedef logic [`DATA_WIDTH/8-1:0] strb_t;

  // Request opcode
  typedef enum logic {
    TCDM_READ  = 1'b0,
    TCDM_WRITE = 1'b1
  } tcdm_op_e;

endpackage : tcdm_pkg

// File: hw/variable_latency_interconnect.sv
// Flat crossbar between cores and TCDM banks
// Fixed latency of two cycles from acceptance to response
// Only back-pressure is a lost arbitration, responses are never stalled

`timescale 1ns/10ps
`include "mempool_macros.svh"

module variable_latency_interconnect (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic [`NUM_CORES-1:0] core_req_valid_i,
  input  mempool_pkg::addr_t    core_req_addr_i  [`NUM_CORES],
  input  tcdm_pkg::tcdm_op_e    core_req_op_i    [`NUM_CORES],
  input  tcdm_pkg::data_t       core_req_wdata_i [`NUM_CORES],
  input  tcdm_pkg::strb_t       core_req_be_i    [`NUM_CORES],
  output logic [`NUM_CORES-1:0] core_req_ready_o,
  output logic [`NUM_CORES-1:0] core_resp_valid_o,
  output tcdm_pkg::data_t       core_resp_rdata_o [`NUM_CORES],
  tcdm_if.master                tile_o [`NUM_TILES]
);
  import mempool_pkg::*;
  import tcdm_pkg::*;

  localparam int unsigned BANK_BITS = $clog2(`NUM_BANKS);
  localparam int unsigned ROW_BITS  = $clog2(`WORDS_PER_BANK);

  logic [BANK_BITS-1:0]  core_bank [`NUM_CORES];
  bank_row_t             core_row  [`NUM_CORES];
  logic [`NUM_CORES-1:0] bank_req  [`NUM_BANKS];
  logic [`NUM_CORES-1:0] bank_gnt  [`NUM_BANKS];
  core_id_t              bank_win  [`NUM_BANKS];

  // Registered bank requests
  logic [`NUM_BANKS-1:0] req_valid_q;
  bank_row_t             req_row_q   [`NUM_BANKS];
  tcdm_op_e              req_op_q    [`NUM_BANKS];
  data_t                 req_wdata_q [`NUM_BANKS];
  strb_t                 req_be_q    [`NUM_BANKS];
  core_id_t              req_ini_q   [`NUM_BANKS];

  // Bank responses, flattened over tiles
  logic [`NUM_BANKS-1:0] rsp_valid;
  core_id_t              rsp_ini   [`NUM_BANKS];
  data_t                 rsp_rdata [`NUM_BANKS];

  logic [`NUM_CORES-1:0] resp_valid_q;
  data_t                 resp_rdata_q [`NUM_CORES];

  // Word interleaving, bank in the low word address bits
  always_comb begin
    for (int c = 0; c < `NUM_CORES; c++) begin
      core_bank[c] = core_req_addr_i[c][2 +: BANK_BITS];
      core_row[c]  = core_req_addr_i[c][2 + BANK_BITS +: ROW_BITS];
    end
  end

  always_comb begin
    core_req_ready_o = '0;
    for (int b = 0; b < `NUM_BANKS; b++) begin
      bank_win[b] = '0;
      for (int c = 0; c < `NUM_CORES; c++) begin
        bank_req[b][c] = core_req_valid_i[c] && (core_bank[c] == BANK_BITS'(b));
        if (bank_gnt[b][c]) begin
          bank_win[b]         = core_id_t'(c);
          core_req_ready_o[c] = 1'b1;
        end
      end
    end
  end

  for (genvar b = 0; b < `NUM_BANKS; b++) begin : gen_arb
    rr_arbiter i_arb (
      .clk_i   (clk_i),
      .rst_n_i (rst_n_i),
      .req_i   (bank_req[b]),
      .adv_i   (|bank_req[b]),
      .gnt_o   (bank_gnt[b])
    );
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      req_valid_q <= '0;
    end else begin
      for (int b = 0; b < `NUM_BANKS; b++) begin
        req_valid_q[b] <= |bank_gnt[b];
      end
    end
  end

  // Winner payload
  always_ff @(posedge clk_i) begin
    for (int b = 0; b < `NUM_BANKS; b++) begin
      req_row_q[b]   <= core_row[bank_win[b]];
      req_op_q[b]    <= core_req_op_i[bank_win[b]];
      req_wdata_q[b] <= core_req_wdata_i[bank_win[b]];
      req_be_q[b]    <= core_req_be_i[bank_win[b]];
      req_ini_q[b]   <= bank_win[b];
    end
  end

  // Global bank t*BANKS_PER_TILE+l lives in tile t as local bank l
  for (genvar t = 0; t < `NUM_TILES; t++) begin : gen_tile_port
    assign tile_o[t].req_valid = req_valid_q[t*`BANKS_PER_TILE +: `BANKS_PER_TILE];
    assign rsp_valid[t*`BANKS_PER_TILE +: `BANKS_PER_TILE] = tile_o[t].resp_valid;
    for (genvar l = 0; l < `BANKS_PER_TILE; l++) begin : gen_bank_port
      localparam int unsigned GB = t * `BANKS_PER_TILE + l;
      assign tile_o[t].req_row[l]   = req_row_q[GB];
      assign tile_o[t].req_op[l]    = req_op_q[GB];
      assign tile_o[t].req_wdata[l] = req_wdata_q[GB];
      assign tile_o[t].req_be[l]    = req_be_q[GB];
      assign tile_o[t].req_ini[l]   = req_ini_q[GB];
      assign rsp_ini[GB]            = tile_o[t].resp_ini[l];
      assign rsp_rdata[GB]          = tile_o[t].resp_rdata[l];
    end
  end

  // Return path, at most one bank answers a given core per cycle
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      resp_valid_q <= '0;
    end else begin
      resp_valid_q <= '0;
      for (int b = 0; b < `NUM_BANKS; b++) begin
        if (rsp_valid[b]) begin
          resp_valid_q[rsp_ini[b]] <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    for (int b = 0; b < `NUM_BANKS; b++) begin
      if (rsp_valid[b]) begin
        resp_rdata_q[rsp_ini[b]] <= rsp_rdata[b];
      end
    end
  end

  assign core_resp_valid_o = resp_valid_q;
  assign core_resp_rdata_o = resp_rdata_q;

endmodule : variable_latency_interconnect

// File: mempool.f
+incdir+hw
hw/mempool_pkg.sv
hw/tcdm_pkg.sv
hw/tcdm_if.sv
hw/rr_arbiter.sv
hw/variable_latency_interconnect.sv
hw/mempool_tile.sv
hw/mempool.sv
verification/mempool_chk.sv
verification/tb_mempool.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the TCDM cluster testbench with Verilator, runs it and scans the log

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f mempool.f \
  --top-module tb_mempool -o tb_mempool
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/tb_mempool > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi

if grep -qx "SIMULATION PASSED" "$LOG"; then
  exit 0
fi
exit 1

// File: verification/mempool_chk.sv
// Protocol checks on the crossbar, attached with bind
// Latency check assumes nothing stalls after acceptance

`timescale 1ns/10ps
`include "mempool_macros.svh"

module mempool_chk (
  input logic                  clk_i,
  input logic                  rst_n_i,
  input logic [`NUM_CORES-1:0] valid_i,
  input logic [`NUM_CORES-1:0] ready_i,
  input logic [`NUM_CORES-1:0] resp_valid_i,
  input logic [`NUM_CORES-1:0] bank_gnt_i [`NUM_BANKS]
);

  // Ready only answers a live request
  ready_needs_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (ready_i & ~valid_i) == '0)
    else $error("Ready raised for a core without a valid request");

  for (genvar b = 0; b < `NUM_BANKS; b++) begin : gen_bank
    single_grant: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      $onehot0(bank_gnt_i[b]))
      else $error("Bank %0d granted to more than one core", b);
  end

  // Response cycle ends three edges after the accepting edge
  for (genvar c = 0; c < `NUM_CORES; c++) begin : gen_core
    fixed_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      resp_valid_i[c] == $past(valid_i[c] && ready_i[c], 3))
      else $error("Core %0d response does not follow acceptance by two cycles", c);
  end

endmodule : mempool_chk

bind variable_latency_interconnect mempool_chk i_chk (
  .clk_i        (clk_i),
  .rst_n_i      (rst_n_i),
  .valid_i      (core_req_valid_i),
  .ready_i      (core_req_ready_o),
  .resp_valid_i (core_resp_valid_o),
  .bank_gnt_i   (bank_gnt)
);

// File: verification/tb_mempool.sv
// Directed and random testbench for the TCDM cluster
// Model keeps a flat copy of all banks indexed by word address
// Random reads rely on the fill test having written every word

`timescale 1ns/10ps
`include "mempool_macros.svh"

module tb_mempool;
  import mempool_pkg::*;
  import tcdm_pkg::*;

  localparam int unsigned MEM_WORDS     = `NUM_BANKS * `WORDS_PER_BANK;
  localparam int unsigned ROW_BITS      = $clog2(`WORDS_PER_BANK);
  localparam int unsigned LATENCY       = 2;
  localparam int unsigned PARTIAL_PAIRS = 64;
  localparam int unsigned RANDOM_CYCLES = 400;
  localparam int unsigned FAIR_CYCLES   = 100;
  localparam int unsigned HOT_BANK      = 3;
  localparam int unsigned NUM_TESTS     = 5;
  // Reset, idle, fill, partial, random and fairness, each with drain slack
  localparam int unsigned TIMEOUT_CYCLES = 16 + 8 + (2 * MEM_WORDS + 8)
    + (2 * PARTIAL_PAIRS + 8) + (RANDOM_CYCLES + 2 * `NUM_CORES + 8)
    + (FAIR_CYCLES + 2 * `NUM_CORES + 8) + 200;

  typedef struct packed {
    logic [31:0] cycle;
    logic        is_read;
    data_t       data;
  } exp_t;

  logic                  clk = 1'b0;
  logic                  rst_n;
  logic [`NUM_CORES-1:0] req_valid;
  addr_t                 req_addr  [`NUM_CORES];
  tcdm_op_e              req_op    [`NUM_CORES];
  data_t                 req_wdata [`NUM_CORES];
  strb_t                 req_be    [`NUM_CORES];
  logic [`NUM_CORES-1:0] req_ready;
  logic [`NUM_CORES-1:0] resp_valid;
  data_t                 resp_rdata [`NUM_CORES];

  data_t       mem_model [MEM_WORDS];
  exp_t        exp_q [`NUM_CORES][$];
  logic [15:0] lfsr_q    = 16'd18982;
  int          cycle_cnt = 0;
  int          err_cnt   = 0;
  int          err_base  = 0;
  int          pass_cnt  = 0;

  mempool i_dut (
    .clk_i             (clk),
    .rst_n_i           (rst_n),
    .core_req_valid_i  (req_valid),
    .core_req_addr_i   (req_addr),
    .core_req_op_i     (req_op),
    .core_req_wdata_i  (req_wdata),
    .core_req_be_i     (req_be),
    .core_req_ready_o  (req_ready),
    .core_resp_valid_o (resp_valid),
    .core_resp_rdata_o (resp_rdata)
  );

  always #20 clk = ~clk;

  // Cycle count and watchdog
  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout, the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v      = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
    end
    return v;
  endfunction

  // Word address wraps over the whole memory
  function automatic int unsigned word_index(input addr_t a);
    return (a >> 2) % MEM_WORDS;
  endfunction

  function automatic addr_t hot_addr();
    return addr_t'((rand_bits(ROW_BITS) * `NUM_BANKS + HOT_BANK) * 4);
  endfunction

  function automatic int outstanding();
    int n;
    n = 0;
    for (int c = 0; c < `NUM_CORES; c++) begin
      n += exp_q[c].size();
    end
    return n;
  endfunction

  // Model checks responses before this edge's acceptances
  always @(posedge clk) begin
    exp_t        e;
    int unsigned idx;
    if (rst_n) begin
      for (int c = 0; c < `NUM_CORES; c++) begin
        if (resp_valid[c]) begin
          assert (exp_q[c].size() != 0) else begin
            err_cnt++;
            $display("Core %0d got a response with no request outstanding", c);
          end
          if (exp_q[c].size() != 0) begin
            e = exp_q[c].pop_front();
            assert (cycle_cnt - e.cycle == LATENCY + 1) else begin
              err_cnt++;
              $display("ERR %0t: core %0d response after %0d cycles, expected %0d",
                       $time, c, cycle_cnt - e.cycle - 1, LATENCY);
            end
            assert (!e.is_read || resp_rdata[c] === e.data) else begin
              err_cnt++;
              $display("ERR %0t: core %0d read %h, expected %h",
                       $time, c, resp_rdata[c], e.data);
            end
          end
        end
        if (req_valid[c] && req_ready[c]) begin
          idx       = word_index(req_addr[c]);
          e.cycle   = cycle_cnt;
          e.is_read = (req_op[c] == TCDM_READ);
          e.data    = mem_model[idx];
          if (!e.is_read) begin
            for (int b = 0; b < `DATA_WIDTH/8; b++) begin
              if (req_be[c][b]) begin
                mem_model[idx][8*b +: 8] = req_wdata[c][8*b +: 8];
              end
            end
          end
          exp_q[c].push_back(e);
        end
      end
    end
  end

  task drive_req(input int c, input tcdm_op_e op, input addr_t a, input data_t d,
                 input strb_t be);
    req_valid[c] <= 1'b1;
    req_addr[c]  <= a;
    req_op[c]    <= op;
    req_wdata[c] <= d;
    req_be[c]    <= be;
  endtask

  // Returns on the accepting edge
  task send(input int c, input tcdm_op_e op, input addr_t a, input data_t d,
            input strb_t be, output int waits);
    drive_req(c, op, a, d, be);
    waits = 0;
    @(posedge clk);
    while (!req_ready[c]) begin
      waits++;
      @(posedge clk);
    end
  endtask

  task wait_drain();
    do begin
      @(negedge clk);
    end while (outstanding() != 0);
    @(posedge clk);
  endtask

  task report_test(input string name);
    int errs;
    errs = err_cnt - err_base;
    if (errs == 0) begin
      pass_cnt++;
      $display("Test %s: done, no errors", name);
    end else begin
      $display("Test %s: %0d errors", name, errs);
    end
    err_base = err_cnt;
  endtask

  task check_idle();
    repeat (8) begin
      @(posedge clk);
      assert (req_ready == '0 && resp_valid == '0) else begin
        err_cnt++;
        $display("ERR %0t: ready %b response valid %b while idle",
                 $time, req_ready, resp_valid);
      end
    end
  endtask

  task fill_and_readback();
    int       waits;
    tcdm_op_e op;
    for (int pass = 0; pass < 2; pass++) begin
      op = (pass == 0) ? TCDM_WRITE : TCDM_READ;
      for (int i = 0; i < MEM_WORDS; i++) begin
        send(0, op, addr_t'(i * 4), {~16'(i), 16'(i)}, '1, waits);
        assert (waits == 0) else begin
          err_cnt++;
          $display("ERR %0t: core 0 request to %h waited %0d cycles", $time, i * 4, waits);
        end
      end
    end
    req_valid[0] <= 1'b0;
    wait_drain();
  endtask

  task partial_writes();
    addr_t a;
    int    waits;
    for (int i = 0; i < PARTIAL_PAIRS; i++) begin
      a = rand_bits(13) << 2;
      send(0, TCDM_WRITE, a, rand_bits(32), strb_t'(rand_bits(4)), waits);
      send(0, TCDM_READ, a, '0, '0, waits);
    end
    req_valid[0] <= 1'b0;
    wait_drain();
  endtask

  // Word addresses reach past the memory size to exercise aliasing
  task random_traffic();
    int cyc;
    cyc = 0;
    do begin
      @(posedge clk);
      for (int c = 0; c < `NUM_CORES; c++) begin
        if (!req_valid[c] || req_ready[c]) begin
          if (cyc < RANDOM_CYCLES && rand_bits(1) == 1) begin
            drive_req(c, tcdm_op_e'(rand_bits(1)), rand_bits(11) << 2, rand_bits(32),
                      strb_t'(rand_bits(4)));
          end else begin
            req_valid[c] <= 1'b0;
          end
        end
      end
      cyc++;
    end while (cyc <= RANDOM_CYCLES || (req_valid & ~req_ready) != '0);
    wait_drain();
  endtask

  task fairness();
    int wait_cnt [`NUM_CORES];
    int cyc;
    cyc = 0;
    for (int c = 0; c < `NUM_CORES; c++) begin
      wait_cnt[c] = 0;
      drive_req(c, TCDM_READ, hot_addr(), '0, '0);
    end
    do begin
      @(posedge clk);
      assert ($countones(req_ready) <= 1) else begin
        err_cnt++;
        $display("ERR %0t: bank %0d accepted %b in one cycle", $time, HOT_BANK, req_ready);
      end
      for (int c = 0; c < `NUM_CORES; c++) begin
        if (req_ready[c]) begin
          wait_cnt[c] = 0;
          if (cyc < FAIR_CYCLES) begin
            drive_req(c, tcdm_op_e'(rand_bits(1)), hot_addr(), rand_bits(32),
                      strb_t'(rand_bits(4)));
          end else begin
            req_valid[c] <= 1'b0;
          end
        end else if (req_valid[c]) begin
          wait_cnt[c]++;
          assert (wait_cnt[c] < `NUM_CORES) else begin
            err_cnt++;
            $display("ERR %0t: core %0d waited %0d cycles for the bank",
                     $time, c, wait_cnt[c]);
          end
        end
      end
      cyc++;
    end while (cyc < FAIR_CYCLES || (req_valid & ~req_ready) != '0);
    wait_drain();
  endtask

  initial begin
    rst_n     <= 1'b0;
    req_valid <= '0;
    for (int c = 0; c < `NUM_CORES; c++) begin
      req_addr[c]  <= '0;
      req_op[c]    <= TCDM_READ;
      req_wdata[c] <= '0;
      req_be[c]    <= '0;
    end
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;

    check_idle();
    report_test("idle after reset");
    fill_and_readback();
    report_test("fill and read back");
    partial_writes();
    report_test("partial writes");
    random_traffic();
    report_test("random traffic");
    fairness();
    report_test("bank fairness");

    $display("Tests passed: %0d of %0d, errors: %0d", pass_cnt, NUM_TESTS, err_cnt);
    if (err_cnt == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule : tb_mempool
